/* verilog/deparser_defines.svh */
`ifndef DEPARSER_DEFINES_SVH
`define DEPARSER_DEFINES_SVH

// segment and head geometry
`define SEG_BYTES 8
`define HEAD_BYTES 16

// phv containers, 2/4/6 byte kinds
`define CONT_PER_KIND 4

// parse-action table
`define NUM_ACTS 4
`define ACT_WIDTH 16
`define TABLE_DEPTH 32

`define VLAN_WIDTH 12

// 4*(2+4+6) bytes of containers plus the discard flag
`define PHV_WIDTH 385
`define DISCARD_BIT 384

// id carried in the control address beat
`define DEPARSER_MOD_ID 3'b101

`endif

/* verilog/deparser_pkg.sv */
`default_nettype none

`include "deparser_defines.svh"

package deparser_pkg;

	typedef logic [`SEG_BYTES*8-1:0] seg_data_t;
	typedef logic [`SEG_BYTES-1:0] seg_keep_t;
	typedef logic [`HEAD_BYTES*8-1:0] head_data_t; // byte k at bits 8k+7:8k
	typedef logic [`HEAD_BYTES-1:0] head_keep_t;
	typedef logic [`HEAD_BYTES/`SEG_BYTES-1:0] head_last_t;
	typedef logic [`PHV_WIDTH-1:0] phv_t;
	typedef logic [`VLAN_WIDTH-1:0] vlan_id_t;
	typedef logic [$clog2(`TABLE_DEPTH)-1:0] table_addr_t;
	typedef logic [`NUM_ACTS*`ACT_WIDTH-1:0] act_entry_t; // action 0 on top
	typedef logic [`ACT_WIDTH-1:0] parse_act_t;
	typedef logic [1:0] field_kind_t; // 01/10/11 = 2/4/6 bytes
	typedef logic [47:0] field_val_t;
	typedef logic [6:0] byte_off_t;

	typedef enum logic [3:0] {IDLE, WAIT_RAM, START, PATCH, FLUSH_SEG0, FLUSH_SEG1,
		FLUSH_BODY, DROP_HEAD, DROP_BODY} depar_state_t;
	typedef enum logic [1:0] {WAIT_HDR, WAIT_ADDR, WAIT_DATA, FLUSH_REST} ctrl_state_t;
	typedef enum logic [1:0] {SEL_SEG0, SEL_SEG1, SEL_BODY} out_sel_t;

endpackage

`default_nettype wire

/* verilog/act_table_loader.sv */
`timescale 1ns/1ps
`default_nettype none

`include "deparser_defines.svh"

module act_table_loader
	import deparser_pkg::*;
(
	input wire clk,
	input wire aresetn,
	input wire seg_data_t ctrl_data,
	input wire ctrl_valid,
	input wire ctrl_last,
	output logic wr_en,
	output table_addr_t wr_addr,
	output act_entry_t wr_data
);

	ctrl_state_t state;
	act_entry_t data_rev;

	// beat byte 0 lands in the entry msb
	always_comb begin
		for (int i = 0; i < `SEG_BYTES; i++)
			data_rev[8*i +: 8] = ctrl_data[8*(`SEG_BYTES-1-i) +: 8];
	end

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			state <= WAIT_HDR;
			wr_en <= 1'b0;
		end else begin
			wr_en <= 1'b0;
			if (ctrl_valid) begin
				case (state)
					WAIT_HDR: if (!ctrl_last) state <= WAIT_ADDR;
					WAIT_ADDR: begin
						if (ctrl_data[2:0] == `DEPARSER_MOD_ID && !ctrl_last)
							state <= WAIT_DATA;
						else
							state <= ctrl_last ? WAIT_HDR : FLUSH_REST; // not ours
					end
					WAIT_DATA: begin
						wr_en <= 1'b1;
						state <= ctrl_last ? WAIT_HDR : FLUSH_REST;
					end
					FLUSH_REST: if (ctrl_last) state <= WAIT_HDR;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ctrl_valid && state == WAIT_ADDR)
			wr_addr <= ctrl_data[8 +: $bits(table_addr_t)];
		if (ctrl_valid && state == WAIT_DATA)
			wr_data <= data_rev;
	end

endmodule

`default_nettype wire

/* verilog/act_table_ram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "deparser_defines.svh"

module act_table_ram
	import deparser_pkg::*;
(
	input wire clk,
	input wire wr_en,
	input wire table_addr_t wr_addr,
	input wire act_entry_t wr_data,
	input wire table_addr_t rd_addr,
	output act_entry_t rd_data
);

	act_entry_t mem [`TABLE_DEPTH];

	// all-zero entries leave packets untouched
	initial begin
		for (int i = 0; i < `TABLE_DEPTH; i++)
			mem[i] = '0;
	end

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
		rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

/* verilog/field_extract.sv */
`timescale 1ns/1ps
`default_nettype none

`include "deparser_defines.svh"

module field_extract
	import deparser_pkg::*;
(
	input wire clk,
	input wire aresetn,
	input wire extract_en,
	input wire phv_t phv,
	input wire parse_act_t act,
	output field_val_t val,
	output field_kind_t kind,
	output byte_off_t offset
);

	localparam int BASE_4B = `CONT_PER_KIND * 16;
	localparam int BASE_6B = BASE_4B + `CONT_PER_KIND * 32;

	logic [1:0] idx;
	field_val_t left, ordered;

	assign idx = act[4:3];

	// container left-aligned, then flipped so val byte 0 is the field msb
	always_comb begin
		left = '0;
		case (act[2:1])
			2'b01: left[47:32] = phv[16*idx +: 16];
			2'b10: left[47:16] = phv[BASE_4B + 32*idx +: 32];
			2'b11: left = phv[BASE_6B + 48*idx +: 48];
			default: left = '0;
		endcase
		for (int j = 0; j < 6; j++)
			ordered[8*j +: 8] = left[8*(5-j) +: 8];
	end

	always_ff @(posedge clk) begin
		if (!aresetn)
			kind <= 2'b00;
		else if (extract_en)
			kind <= act[0] ? act[2:1] : 2'b00; // invalid action patches nothing
	end

	always_ff @(posedge clk) begin
		if (extract_en) begin
			val <= ordered;
			offset <= act[12:6];
		end
	end

endmodule

`default_nettype wire

/* verilog/head_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "deparser_defines.svh"

module head_buffer
	import deparser_pkg::*;
(
	input wire clk,
	input wire aresetn,
	input wire head_load,
	input wire head_data_t head_data,
	input wire head_keep_t head_keep,
	input wire head_last_t head_last,
	input wire patch_en,
	input wire field_val_t val [`NUM_ACTS],
	input wire field_kind_t kind [`NUM_ACTS],
	input wire byte_off_t offset [`NUM_ACTS],
	input wire out_load,
	input wire out_sel_t out_sel,
	input wire seg_data_t body_data,
	input wire seg_keep_t body_keep,
	input wire body_last,
	output head_last_t stored_last,
	output seg_data_t out_data,
	output seg_keep_t out_keep,
	output logic out_last
);

	head_data_t data_q, patched;
	head_keep_t keep_q;

	// later actions overwrite earlier ones, bytes past the head are lost
	always_comb begin
		patched = data_q;
		for (int a = 0; a < `NUM_ACTS; a++)
			for (int j = 0; j < 6; j++)
				if (j < 2*kind[a] && offset[a] + j < `HEAD_BYTES)
					patched[8*(offset[a]+j) +: 8] = val[a][8*j +: 8];
	end

	always_ff @(posedge clk) begin
		if (head_load) begin
			data_q <= head_data;
			keep_q <= head_keep;
		end else if (patch_en) begin
			data_q <= patched;
		end
	end

	always_ff @(posedge clk) begin
		if (!aresetn)
			stored_last <= '0;
		else if (head_load)
			stored_last <= head_last;
	end

	always_ff @(posedge clk) begin
		if (out_load) begin
			case (out_sel)
				SEL_SEG0: begin
					out_data <= data_q[0 +: `SEG_BYTES*8];
					out_keep <= keep_q[0 +: `SEG_BYTES];
					out_last <= stored_last[0];
				end
				SEL_SEG1: begin
					out_data <= data_q[`SEG_BYTES*8 +: `SEG_BYTES*8];
					out_keep <= keep_q[`SEG_BYTES +: `SEG_BYTES];
					out_last <= stored_last[1];
				end
				default: begin
					out_data <= body_data;
					out_keep <= body_keep;
					out_last <= body_last;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* verilog/deparse_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module deparse_fsm
	import deparser_pkg::*;
(
	input wire clk,
	input wire aresetn,
	input wire phv_empty,
	input wire discard,
	input wire vlan_empty,
	input wire head_empty,
	input wire head_last_t head_last,
	input wire head_last_t stored_last,
	input wire body_empty,
	input wire body_last,
	input wire out_ready,
	output logic phv_rd_en,
	output logic vlan_rd_en,
	output logic head_rd_en,
	output logic body_rd_en,
	output logic extract_en,
	output logic head_load,
	output logic patch_en,
	output logic out_load,
	output out_sel_t out_sel,
	output logic out_valid
);

	depar_state_t state, state_next;

	always_comb begin
		state_next = state;
		phv_rd_en = 1'b0;
		vlan_rd_en = 1'b0;
		head_rd_en = 1'b0;
		body_rd_en = 1'b0;
		extract_en = 1'b0;
		head_load = 1'b0;
		patch_en = 1'b0;
		out_load = 1'b0;
		out_sel = SEL_SEG0;
		case (state)
			IDLE: if (!vlan_empty) state_next = WAIT_RAM;
			WAIT_RAM: state_next = START; // table read in flight
			START: begin
				if (!head_empty && !phv_empty) begin
					if (discard) begin
						phv_rd_en = 1'b1;
						state_next = DROP_HEAD;
					end else begin
						extract_en = 1'b1;
						head_load = 1'b1;
						state_next = PATCH;
					end
				end
			end
			PATCH: begin
				patch_en = 1'b1;
				state_next = FLUSH_SEG0;
			end
			FLUSH_SEG0: begin
				if (out_ready) begin
					out_load = 1'b1;
					phv_rd_en = 1'b1; // packet inputs retire here
					vlan_rd_en = 1'b1;
					head_rd_en = 1'b1;
					state_next = stored_last[0] ? IDLE : FLUSH_SEG1;
				end
			end
			FLUSH_SEG1: begin
				out_sel = SEL_SEG1;
				if (out_ready) begin
					out_load = 1'b1;
					state_next = stored_last[1] ? IDLE : FLUSH_BODY;
				end
			end
			FLUSH_BODY: begin
				out_sel = SEL_BODY;
				if (out_ready && !body_empty) begin
					out_load = 1'b1;
					body_rd_en = 1'b1;
					if (body_last) state_next = IDLE;
				end
			end
			DROP_HEAD: begin
				head_rd_en = 1'b1;
				vlan_rd_en = 1'b1;
				state_next = |head_last ? IDLE : DROP_BODY;
			end
			DROP_BODY: begin
				if (!body_empty) begin
					body_rd_en = 1'b1;
					if (body_last) state_next = IDLE;
				end
			end
			default: state_next = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			state <= IDLE;
			out_valid <= 1'b0;
		end else begin
			state <= state_next;
			out_valid <= out_load; // data regs load on the same edge
		end
	end

endmodule

`default_nettype wire

/* verilog/deparser_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "deparser_defines.svh"

module deparser_top
	import deparser_pkg::*;
(
	input wire clk,
	input wire aresetn,
	input wire phv_t phv,
	input wire phv_empty,
	output logic phv_rd_en,
	input wire vlan_id_t vlan_id,
	input wire vlan_empty,
	output logic vlan_rd_en,
	input wire head_data_t head_data,
	input wire head_keep_t head_keep,
	input wire head_last_t head_last,
	input wire head_empty,
	output logic head_rd_en,
	input wire seg_data_t body_data,
	input wire seg_keep_t body_keep,
	input wire body_last,
	input wire body_empty,
	output logic body_rd_en,
	output seg_data_t out_data,
	output seg_keep_t out_keep,
	output logic out_last,
	output logic out_valid,
	input wire out_ready,
	input wire seg_data_t ctrl_data,
	input wire ctrl_valid,
	input wire ctrl_last
);

	logic wr_en;
	table_addr_t wr_addr;
	act_entry_t wr_data;
	act_entry_t act_entry;
	logic extract_en, head_load, patch_en, out_load;
	out_sel_t out_sel;
	head_last_t stored_last;
	field_val_t val [`NUM_ACTS];
	field_kind_t kind [`NUM_ACTS];
	byte_off_t offset [`NUM_ACTS];

	act_table_loader u_loader (.clk(clk), .aresetn(aresetn), .ctrl_data(ctrl_data),
		.ctrl_valid(ctrl_valid), .ctrl_last(ctrl_last), .wr_en(wr_en), .wr_addr(wr_addr),
		.wr_data(wr_data));

	// entry index from vlan id bits 8..4
	act_table_ram u_ram (.clk(clk), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
		.rd_addr(vlan_id[8:4]), .rd_data(act_entry));

	for (genvar a = 0; a < `NUM_ACTS; a++) begin : g_fx
		field_extract u_fx (.clk(clk), .aresetn(aresetn), .extract_en(extract_en), .phv(phv),
			.act(act_entry[`ACT_WIDTH*(`NUM_ACTS-1-a) +: `ACT_WIDTH]),
			.val(val[a]), .kind(kind[a]), .offset(offset[a]));
	end

	head_buffer u_head (.clk(clk), .aresetn(aresetn), .head_load(head_load),
		.head_data(head_data), .head_keep(head_keep), .head_last(head_last),
		.patch_en(patch_en), .val(val), .kind(kind), .offset(offset), .out_load(out_load),
		.out_sel(out_sel), .body_data(body_data), .body_keep(body_keep), .body_last(body_last),
		.stored_last(stored_last), .out_data(out_data), .out_keep(out_keep),
		.out_last(out_last));

	deparse_fsm u_fsm (.clk(clk), .aresetn(aresetn), .phv_empty(phv_empty),
		.discard(phv[`DISCARD_BIT]), .vlan_empty(vlan_empty), .head_empty(head_empty),
		.head_last(head_last), .stored_last(stored_last), .body_empty(body_empty),
		.body_last(body_last), .out_ready(out_ready), .phv_rd_en(phv_rd_en),
		.vlan_rd_en(vlan_rd_en), .head_rd_en(head_rd_en), .body_rd_en(body_rd_en),
		.extract_en(extract_en), .head_load(head_load), .patch_en(patch_en),
		.out_load(out_load), .out_sel(out_sel), .out_valid(out_valid));

endmodule

`default_nettype wire

/* test/tb_deparser.sv */
`timescale 1ns/1ps
`default_nettype none

`include "deparser_defines.svh"

module tb_deparser
	import deparser_pkg::*;
();

	logic clk, aresetn;
	phv_t phv;
	logic phv_empty, phv_rd_en;
	vlan_id_t vlan_id;
	logic vlan_empty, vlan_rd_en;
	head_data_t head_data;
	head_keep_t head_keep;
	head_last_t head_last;
	logic head_empty, head_rd_en;
	seg_data_t body_data;
	seg_keep_t body_keep;
	logic body_last, body_empty, body_rd_en;
	seg_data_t out_data;
	seg_keep_t out_keep;
	logic out_last, out_valid, out_ready;
	seg_data_t ctrl_data;
	logic ctrl_valid, ctrl_last;

	// fwft fifo contents
	phv_t phv_q [$];
	vlan_id_t vlan_q [$];
	head_data_t hd_q [$];
	head_keep_t hk_q [$];
	head_last_t hl_q [$];
	seg_data_t bd_q [$];
	seg_keep_t bk_q [$];
	logic bl_q [$];

	seg_data_t exp_data [$];
	seg_keep_t exp_keep [$];
	logic exp_last [$];

	act_entry_t tbl [`TABLE_DEPTH]; // shadow of the action table
	logic pop_phv, pop_vlan, pop_head, pop_body;
	logic rand_ready;
	logic [7:0] lfsr;
	string test_name;

	deparser_top dut (.clk(clk), .aresetn(aresetn), .phv(phv), .phv_empty(phv_empty),
		.phv_rd_en(phv_rd_en), .vlan_id(vlan_id), .vlan_empty(vlan_empty),
		.vlan_rd_en(vlan_rd_en), .head_data(head_data), .head_keep(head_keep),
		.head_last(head_last), .head_empty(head_empty), .head_rd_en(head_rd_en),
		.body_data(body_data), .body_keep(body_keep), .body_last(body_last),
		.body_empty(body_empty), .body_rd_en(body_rd_en), .out_data(out_data),
		.out_keep(out_keep), .out_last(out_last), .out_valid(out_valid),
		.out_ready(out_ready), .ctrl_data(ctrl_data), .ctrl_valid(ctrl_valid),
		.ctrl_last(ctrl_last));

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// taps 8,6,5,4
	function automatic logic next_bit();
		logic fb;
		fb = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];
		lfsr = {lfsr[6:0], fb};
		return fb;
	endfunction

	function automatic logic [63:0] rand_bits(int n);
		logic [63:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
			r = {r[62:0], next_bit()};
		return r;
	endfunction

	function automatic parse_act_t mk_act(field_kind_t kind, logic [1:0] idx, byte_off_t off);
		return {3'b000, off, 1'b0, idx, kind, 1'b1};
	endfunction

	// field msb goes at the offset and later actions win
	function automatic head_data_t model_patch(head_data_t h, act_entry_t e, phv_t p);
		head_data_t r;
		parse_act_t act;
		field_val_t cv;
		int n, off, idx;
		r = h;
		for (int a = 0; a < `NUM_ACTS; a++) begin
			act = e[16*(`NUM_ACTS-1-a) +: 16];
			idx = int'(act[4:3]);
			off = int'(act[12:6]);
			n = 0;
			cv = '0;
			if (act[0]) begin
				case (act[2:1])
					2'b01: begin
						n = 2;
						cv[15:0] = p[16*idx +: 16];
					end
					2'b10: begin
						n = 4;
						cv[31:0] = p[64 + 32*idx +: 32];
					end
					2'b11: begin
						n = 6;
						cv = p[192 + 48*idx +: 48];
					end
					default: n = 0;
				endcase
			end
			for (int j = 0; j < n; j++)
				if (off + j < `HEAD_BYTES) // bytes past 15 dropped
					r[8*(off+j) +: 8] = cv[8*(n-1-j) +: 8];
		end
		return r;
	endfunction

	task automatic abort_run(string msg);
		$display("%s", msg);
		$display("SIMULATION FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_seg(seg_data_t exp, seg_data_t act);
		if (exp !== act)
			abort_run($sformatf("mismatch in test %s: out_data expected %h actual %h",
				test_name, exp, act));
	endtask

	task automatic check_keep(seg_keep_t exp, seg_keep_t act);
		if (exp !== act)
			abort_run($sformatf("mismatch in test %s: out_keep expected %h actual %h",
				test_name, exp, act));
	endtask

	task automatic check_last(logic exp, logic act);
		if (exp !== act)
			abort_run($sformatf("mismatch in test %s: out_last expected %b actual %b",
				test_name, exp, act));
	endtask

	task automatic score_beat;
		seg_data_t d;
		seg_keep_t k;
		logic l;
		if (exp_data.size() == 0) begin
			abort_run($sformatf("test %s: output beat arrived with nothing expected",
				test_name));
		end else begin
			d = exp_data.pop_front();
			k = exp_keep.pop_front();
			l = exp_last.pop_front();
			check_seg(d, out_data);
			check_keep(k, out_keep);
			check_last(l, out_last);
		end
	endtask

	// rd_en is stable mid-cycle so the pop lands after the next edge
	always @(negedge clk) begin
		pop_phv = aresetn && phv_rd_en;
		pop_vlan = aresetn && vlan_rd_en;
		pop_head = aresetn && head_rd_en;
		pop_body = aresetn && body_rd_en;
		if (aresetn && out_valid)
			score_beat();
	end

	task automatic refresh_fifos;
		phv_empty = (phv_q.size() == 0);
		phv = phv_empty ? '0 : phv_q[0];
		vlan_empty = (vlan_q.size() == 0);
		vlan_id = vlan_empty ? '0 : vlan_q[0];
		head_empty = (hd_q.size() == 0);
		head_data = head_empty ? '0 : hd_q[0];
		head_keep = head_empty ? '0 : hk_q[0];
		head_last = head_empty ? '0 : hl_q[0];
		body_empty = (bd_q.size() == 0);
		body_data = body_empty ? '0 : bd_q[0];
		body_keep = body_empty ? '0 : bk_q[0];
		body_last = body_empty ? 1'b0 : bl_q[0];
	endtask

	initial begin
		pop_phv = 1'b0;
		pop_vlan = 1'b0;
		pop_head = 1'b0;
		pop_body = 1'b0;
		out_ready = 1'b1;
		refresh_fifos();
		forever begin
			@(posedge clk);
			#1;
			if (pop_phv) void'(phv_q.pop_front());
			if (pop_vlan) void'(vlan_q.pop_front());
			if (pop_head) begin
				void'(hd_q.pop_front());
				void'(hk_q.pop_front());
				void'(hl_q.pop_front());
			end
			if (pop_body) begin
				void'(bd_q.pop_front());
				void'(bk_q.pop_front());
				void'(bl_q.pop_front());
			end
			out_ready = rand_ready ? next_bit() : 1'b1;
			refresh_fifos();
		end
	end

	task automatic write_entry(logic [2:0] id, table_addr_t addr, act_entry_t e);
		seg_data_t rev;
		for (int i = 0; i < 8; i++)
			rev[8*i +: 8] = e[8*(7-i) +: 8]; // beat byte 0 is the entry msb
		@(posedge clk);
		#1;
		ctrl_valid = 1'b1;
		ctrl_last = 1'b0;
		ctrl_data = '0;
		@(posedge clk);
		#1;
		ctrl_data = {48'h0, 3'b000, addr, 5'b00000, id};
		@(posedge clk);
		#1;
		ctrl_data = rev;
		ctrl_last = 1'b1;
		@(posedge clk);
		#1;
		ctrl_valid = 1'b0;
		ctrl_last = 1'b0;
		ctrl_data = '0;
		if (id == `DEPARSER_MOD_ID)
			tbl[addr] = e;
		repeat (3) @(posedge clk);
	endtask

	task automatic send_packet(table_addr_t addr, logic discard, head_last_t hlast,
		head_keep_t hkeep, int nbody);
		phv_t p;
		head_data_t h, hp;
		seg_data_t b;
		seg_keep_t bk;
		int nb;
		@(negedge clk);
		nb = (hlast == 2'b00) ? nbody : 0;
		p = '0;
		for (int k = 0; k < 6; k++)
			p[64*k +: 64] = rand_bits(64);
		p[`DISCARD_BIT] = discard;
		h[63:0] = rand_bits(64);
		h[127:64] = rand_bits(64);
		phv_q.push_back(p);
		vlan_q.push_back({3'b010, addr, 4'h3});
		hd_q.push_back(h);
		hk_q.push_back(hkeep);
		hl_q.push_back(hlast);
		if (!discard) begin
			hp = model_patch(h, tbl[addr], p);
			exp_data.push_back(hp[63:0]);
			exp_keep.push_back(hkeep[7:0]);
			exp_last.push_back(hlast[0]);
			if (!hlast[0]) begin
				exp_data.push_back(hp[127:64]);
				exp_keep.push_back(hkeep[15:8]);
				exp_last.push_back(hlast[1]);
			end
		end
		for (int i = 0; i < nb; i++) begin
			b = rand_bits(64);
			bk = (i == nb - 1) ? 8'h1f : 8'hff;
			bd_q.push_back(b);
			bk_q.push_back(bk);
			bl_q.push_back(i == nb - 1);
			if (!discard) begin
				exp_data.push_back(b);
				exp_keep.push_back(bk);
				exp_last.push_back(i == nb - 1);
			end
		end
	endtask

	function automatic logic all_drained();
		return exp_data.size() == 0 && phv_q.size() == 0 && vlan_q.size() == 0 &&
			hd_q.size() == 0 && bd_q.size() == 0;
	endfunction

	task automatic wait_drain(int limit);
		int cnt;
		cnt = 0;
		while (!all_drained() && cnt < limit) begin
			@(posedge clk);
			cnt++;
		end
		if (!all_drained())
			abort_run($sformatf("timeout in test %s: packets did not drain", test_name));
		else
			repeat (12) @(posedge clk); // room for any stray beat
	endtask

	task automatic patch_all_kinds;
		act_entry_t e;
		test_name = "patch_all_kinds";
		e = {mk_act(2'b01, 2'd1, 7'd0), mk_act(2'b10, 2'd2, 7'd2),
			mk_act(2'b11, 2'd3, 7'd7), mk_act(2'b01, 2'd0, 7'd14)};
		write_entry(`DEPARSER_MOD_ID, 5'd3, e);
		send_packet(5'd3, 1'b0, 2'b00, 16'hffff, 3);
		wait_drain(400);
	endtask

	task automatic overlap_wins;
		act_entry_t e;
		test_name = "overlap";
		// action 1 also runs past the head end
		e = {mk_act(2'b11, 2'd0, 7'd4), mk_act(2'b11, 2'd1, 7'd13), 16'h0000,
			mk_act(2'b10, 2'd2, 7'd6)};
		write_entry(`DEPARSER_MOD_ID, 5'd5, e);
		send_packet(5'd5, 1'b0, 2'b00, 16'hffff, 1);
		wait_drain(400);
	endtask

	task automatic wrong_id_ignored;
		test_name = "wrong_id";
		write_entry(3'b011, 5'd9, {4{mk_act(2'b01, 2'd2, 7'd1)}});
		send_packet(5'd9, 1'b0, 2'b00, 16'hffff, 2);
		wait_drain(400);
	endtask

	task automatic discard_drops;
		test_name = "discard";
		send_packet(5'd3, 1'b1, 2'b10, 16'hffff, 0);
		send_packet(5'd5, 1'b1, 2'b00, 16'hffff, 2);
		send_packet(5'd3, 1'b0, 2'b10, 16'h0fff, 0); // partial second segment
		wait_drain(600);
	endtask

	task automatic short_head;
		test_name = "short";
		send_packet(5'd5, 1'b0, 2'b01, 16'h003f, 0);
		wait_drain(400);
	endtask

	task automatic random_backpressure;
		test_name = "random_ready";
		rand_ready = 1'b1;
		send_packet(5'd3, 1'b0, 2'b00, 16'hffff, 4);
		send_packet(5'd5, 1'b0, 2'b01, 16'h00ff, 0);
		send_packet(5'd9, 1'b0, 2'b00, 16'hffff, 2);
		wait_drain(2000);
		rand_ready = 1'b0;
	endtask

	initial begin
		lfsr = 8'd84;
		rand_ready = 1'b0;
		test_name = "reset";
		aresetn = 1'b0;
		ctrl_data = '0;
		ctrl_valid = 1'b0;
		ctrl_last = 1'b0;
		for (int i = 0; i < `TABLE_DEPTH; i++)
			tbl[i] = '0;
		repeat (16) @(posedge clk);
		#1;
		aresetn = 1'b1;
		repeat (4) @(posedge clk);
		patch_all_kinds();
		overlap_wins();
		wrong_id_ignored();
		discard_drops();
		short_head();
		random_backpressure();
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* deparser.f */
+incdir+verilog
verilog/deparser_pkg.sv
verilog/act_table_loader.sv
verilog/act_table_ram.sv
verilog/field_extract.sv
verilog/head_buffer.sv
verilog/deparse_fsm.sv
verilog/deparser_top.sv
test/tb_deparser.sv

/* run_sim.sh */
#!/bin/sh
# build with verilator, then look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module tb_deparser -f deparser.f -o tb_deparser_sim &&
./obj_dir/tb_deparser_sim | tee /dev/stderr | grep -q "SIMULATION PASSED" &&
echo "run ok" || { echo "run failed"; exit 1; }
